/* apb_cfg_regs.sv */
// ====================
// no wait states, unknown offsets answer with pslverr
// writes to the status register are dropped
// ====================
`timescale 1ns/1ps
`default_nettype none

module apb_cfg_regs (
  input  logic               clk_sys,
  input  logic               RESET,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  mac_pkg::apb_addr_t paddr_i,
  input  mac_pkg::apb_data_t pwdata_i,
  input  logic [1:0]         disk_ins_i,
  input  logic [1:0]         disk_ds_i,
  input  logic               turbo_on_i,
  output mac_pkg::apb_data_t prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  output logic               turbo_req_o,
  output logic               soft_reset_o,
  output mac_pkg::ram_size_t mem_size_o,
  output logic [7:0]         video_arx_o,
  output logic [7:0]         video_ary_o
);
  import mac_pkg::*;

  logic [5:0] ctrl_q;
  logic       access;
  logic       addr_ok;
  apb_data_t  status;

  // transfer completes in the access phase
  assign access  = psel_i & penable_i;
  assign addr_ok = (paddr_i == REG_CTRL) || (paddr_i == REG_STATUS);

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      ctrl_q <= '0;
    end else if (access && pwrite_i && (paddr_i == REG_CTRL)) begin
      ctrl_q <= pwdata_i[5:0];
    end
  end

  // drive flags per drive pair, internal drive in the low bits
  assign status = {27'd0, turbo_on_i, disk_ds_i[1], disk_ins_i[1],
                   disk_ds_i[0], disk_ins_i[0]};

  always_comb begin
    case (paddr_i)
      REG_CTRL:   prdata_o = {26'd0, ctrl_q};
      REG_STATUS: prdata_o = status;
      default:    prdata_o = '0;
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~addr_ok;

  // ==================
  // control field decode
  // ==================
  assign turbo_req_o  = ctrl_q[CTRL_TURBO];
  assign soft_reset_o = ctrl_q[CTRL_SOFT_RST];
  assign mem_size_o   = ctrl_q[CTRL_MEM_LSB +: 2];

  // 16:9 when wide, else 4:3
  assign video_arx_o = ctrl_q[CTRL_WIDE] ? 8'd16 : 8'd4;
  assign video_ary_o = ctrl_q[CTRL_WIDE] ? 8'd9  : 8'd3;

endmodule

`default_nettype wire

/* clk_enables.sv */
// ====================
// strobes are one clk_sys wide and held low while RESET is high
// ====================
`timescale 1ns/1ps
`default_nettype none

module clk_enables (
  input  logic clk_sys,
  input  logic RESET,
  output logic cep_o,
  output logic cen_o,
  output logic ce_pixel_o
);

  logic [2:0] div_q;

  // free-running phase count, one bus cycle per 8 clocks
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 3'd1;
    end
  end

  // registered decodes so the strobes come out glitch-free
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      cep_o      <= 1'b0;
      cen_o      <= 1'b0;
      ce_pixel_o <= 1'b0;
    end else begin
      cep_o      <= (div_q == 3'd0);
      // late phase sits half a bus cycle after cep
      cen_o      <= (div_q == 3'd4);
      ce_pixel_o <= (div_q[1:0] == 2'd0);
    end
  end

endmodule

`default_nettype wire

/* drive_monitor.sv */
// ====================
// turbo waits for TURBO_ACKS block acknowledges after each system reset
// ====================
`timescale 1ns/1ps
`default_nettype none

module drive_monitor #(
  parameter int ACT_HOLD   = 1000000,
  parameter int TURBO_ACKS = 20
) (
  input  logic       clk_sys,
  input  logic       RESET,
  input  logic       sys_rst_n_i,
  input  logic       turbo_req_i,
  input  logic       sd_ack_i,
  input  logic [1:0] disk_motor_i,
  input  logic [1:0] disk_act_i,
  input  logic       bus_slot_i,
  input  logic       dl_active_i,
  output logic       turbo_o,
  output logic       led_user_o
);

  localparam int ACK_W  = $clog2(TURBO_ACKS + 1);
  localparam int HOLD_W = $clog2(ACT_HOLD + 1);

  logic              ack_q;
  logic [ACK_W-1:0]  ack_cnt_q;
  logic [HOLD_W-1:0] hold_cnt_q;
  logic              act_held_q;

  // booting from the block device is unsafe in turbo
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      ack_q     <= 1'b0;
      ack_cnt_q <= ACK_W'(TURBO_ACKS);
      turbo_o   <= 1'b0;
    end else begin
      ack_q <= sd_ack_i;
      if (!sys_rst_n_i) begin
        ack_cnt_q <= ACK_W'(TURBO_ACKS);
        turbo_o   <= 1'b0;
      end else begin
        // floppy access cancels the hold-off
        if (|disk_motor_i) begin
          ack_cnt_q <= '0;
        end else if (ack_q && !sd_ack_i && (ack_cnt_q != '0)) begin
          ack_cnt_q <= ack_cnt_q - 1'b1;
        end
        if ((ack_cnt_q == '0) && bus_slot_i) begin
          turbo_o <= turbo_req_i;
        end
      end
    end
  end

  // stretch short activity pulses so the LED is visible
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      hold_cnt_q <= '0;
      act_held_q <= 1'b0;
    end else begin
      if (|disk_act_i) begin
        hold_cnt_q <= HOLD_W'(ACT_HOLD);
      end else if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
      act_held_q <= (hold_cnt_q != '0);
    end
  end

  assign led_user_o = dl_active_i | (act_held_q ^ (|disk_motor_i));

endmodule

`default_nettype wire

/* image_loader.sv */
// ====================
// host sends even then odd byte and must hold off while dl_wait_o is high
// a write needs one low-slot gap before the slot it uses
// ====================
`timescale 1ns/1ps
`default_nettype none

module image_loader (
  input  logic                clk_sys,
  input  logic                RESET,
  input  logic                sys_rst_n_i,
  input  logic                dl_active_i,
  input  mac_pkg::img_index_t dl_index_i,
  input  logic                dl_wr_i,
  input  mac_pkg::dl_addr_t   dl_addr_i,
  input  mac_pkg::byte_t      dl_data_i,
  input  logic                bus_slot_i,
  input  logic [1:0]          disk_eject_i,
  output logic                dl_wait_o,
  output mac_pkg::mem_addr_t  mem_addr_o,
  output mac_pkg::word_t      mem_din_o,
  output logic                mem_we_o,
  output logic [1:0]          disk_ins_o,
  output logic [1:0]          disk_ds_o
);
  import mac_pkg::*;

  ld_state_t  state_q;
  byte_t      even_q;
  mem_addr_t  word_addr;
  mem_addr_t  region_base;
  mem_addr_t  last_word_q;
  logic       pair_done;
  logic       slot_q;
  logic       active_q;
  logic       dl_end;
  logic [1:0] end_drive;
  logic [1:0] dsk_ds_q;
  logic [1:0] dsk_ss_q;

  assign word_addr = {1'b0, dl_addr_i[24:1]};
  assign pair_done = dl_wr_i & dl_addr_i[0];

  always_comb begin
    case (dl_index_i)
      IMG_ROM:        region_base = ROM_BASE;
      IMG_FLOPPY_INT: region_base = FLOPPY_INT_BASE;
      default:        region_base = FLOPPY_EXT_BASE;
    endcase
  end

  // ==================
  // byte packing
  // ==================
  always_ff @(posedge clk_sys) begin
    if (dl_wr_i && !dl_addr_i[0]) begin
      even_q <= dl_data_i;
    end
    // address and data stay put until the write is done
    if (pair_done) begin
      mem_din_o  <= {even_q, dl_data_i};
      mem_addr_o <= region_base + word_addr;
    end
    // an empty download after a system reset finds no image
    if (dl_wr_i) begin
      last_word_q <= word_addr;
    end else if (!sys_rst_n_i) begin
      last_word_q <= '0;
    end
  end

  // ==================
  // write pacing against the bus slot
  // ==================
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      state_q   <= LD_IDLE;
      dl_wait_o <= 1'b0;
      slot_q    <= 1'b0;
    end else begin
      slot_q <= bus_slot_i;
      case (state_q)
        LD_IDLE: begin
          if (pair_done) begin
            state_q   <= LD_PENDING;
            dl_wait_o <= 1'b1;
          end
        end
        LD_PENDING: begin
          if (!bus_slot_i) begin
            state_q <= LD_ARMED;
          end
        end
        // slot rose too early, wait for the next gap
        LD_ARMED: begin
          state_q <= bus_slot_i ? LD_PENDING : LD_WRITING;
        end
        LD_WRITING: begin
          if (slot_q && !bus_slot_i) begin
            state_q   <= LD_IDLE;
            dl_wait_o <= 1'b0;
          end
        end
        default: state_q <= LD_IDLE;
      endcase
    end
  end

  assign mem_we_o = (state_q == LD_WRITING) & bus_slot_i;

  // ==================
  // floppy side detection
  // ==================
  assign dl_end       = active_q & ~dl_active_i;
  assign end_drive[0] = dl_end & (dl_index_i == IMG_FLOPPY_INT);
  assign end_drive[1] = dl_end & (dl_index_i == IMG_FLOPPY_EXT);

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      active_q <= 1'b0;
      dsk_ds_q <= '0;
      dsk_ss_q <= '0;
    end else begin
      active_q <= dl_active_i;
      for (int d = 0; d < 2; d++) begin
        if (disk_eject_i[d]) begin
          dsk_ds_q[d] <= 1'b0;
          dsk_ss_q[d] <= 1'b0;
        end else if (end_drive[d]) begin
          // unknown sizes leave the drive empty
          dsk_ds_q[d] <= (last_word_q == FLOPPY_DS_WORDS);
          dsk_ss_q[d] <= (last_word_q == FLOPPY_SS_WORDS);
        end
      end
    end
  end

  assign disk_ins_o = dsk_ds_q | dsk_ss_q;
  assign disk_ds_o  = dsk_ds_q;

endmodule

`default_nettype wire

/* mac_glue_top.sv */
// ====================
// single clock domain, all inputs synchronous to clk_sys except RESET
// ====================
`timescale 1ns/1ps
`default_nettype none

module mac_glue_top #(
  parameter int RESET_BITS = 16,
  parameter int ACT_HOLD   = 1000000,
  parameter int TURBO_ACKS = 20
) (
  input  logic                clk_sys,
  input  logic                RESET,
  input  logic                pll_locked_i,
  input  logic                button_reset_i,
  // APB register port
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  mac_pkg::apb_addr_t  paddr_i,
  input  mac_pkg::apb_data_t  pwdata_i,
  output mac_pkg::apb_data_t  prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // host download
  input  logic                dl_active_i,
  input  mac_pkg::img_index_t dl_index_i,
  input  logic                dl_wr_i,
  input  mac_pkg::dl_addr_t   dl_addr_i,
  input  mac_pkg::byte_t      dl_data_i,
  output logic                dl_wait_o,
  // memory write port
  input  logic                bus_slot_i,
  output mac_pkg::mem_addr_t  mem_addr_o,
  output mac_pkg::word_t      mem_din_o,
  output logic                mem_we_o,
  // drives and block device
  input  logic [1:0]          disk_eject_i,
  input  logic [1:0]          disk_motor_i,
  input  logic [1:0]          disk_act_i,
  input  logic                sd_ack_i,
  output logic                cep_o,
  output logic                ce_pixel_o,
  output logic                sys_rst_n_o,
  output mac_pkg::ram_size_t  ram_size_o,
  output logic [7:0]          video_arx_o,
  output logic [7:0]          video_ary_o,
  output logic                turbo_o,
  output logic                led_user_o
);
  import mac_pkg::*;

  logic       cen;
  logic       turbo_req;
  logic       soft_reset;
  ram_size_t  mem_size;
  logic [1:0] disk_ins;
  logic [1:0] disk_ds;

  clk_enables u_clk_enables (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .cep_o      (cep_o),
    .cen_o      (cen),
    .ce_pixel_o (ce_pixel_o)
  );

  reset_seq #(
    .RESET_BITS (RESET_BITS)
  ) u_reset_seq (
    .clk_sys        (clk_sys),
    .RESET          (RESET),
    .pll_locked_i   (pll_locked_i),
    .soft_reset_i   (soft_reset),
    .button_reset_i (button_reset_i),
    .cen_i          (cen),
    .mem_size_i     (mem_size),
    .sys_rst_n_o    (sys_rst_n_o),
    .ram_size_o     (ram_size_o)
  );

  apb_cfg_regs u_apb_cfg_regs (
    .clk_sys      (clk_sys),
    .RESET        (RESET),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .disk_ins_i   (disk_ins),
    .disk_ds_i    (disk_ds),
    .turbo_on_i   (turbo_o),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .turbo_req_o  (turbo_req),
    .soft_reset_o (soft_reset),
    .mem_size_o   (mem_size),
    .video_arx_o  (video_arx_o),
    .video_ary_o  (video_ary_o)
  );

  image_loader u_image_loader (
    .clk_sys      (clk_sys),
    .RESET        (RESET),
    .sys_rst_n_i  (sys_rst_n_o),
    .dl_active_i  (dl_active_i),
    .dl_index_i   (dl_index_i),
    .dl_wr_i      (dl_wr_i),
    .dl_addr_i    (dl_addr_i),
    .dl_data_i    (dl_data_i),
    .bus_slot_i   (bus_slot_i),
    .disk_eject_i (disk_eject_i),
    .dl_wait_o    (dl_wait_o),
    .mem_addr_o   (mem_addr_o),
    .mem_din_o    (mem_din_o),
    .mem_we_o     (mem_we_o),
    .disk_ins_o   (disk_ins),
    .disk_ds_o    (disk_ds)
  );

  drive_monitor #(
    .ACT_HOLD   (ACT_HOLD),
    .TURBO_ACKS (TURBO_ACKS)
  ) u_drive_monitor (
    .clk_sys      (clk_sys),
    .RESET        (RESET),
    .sys_rst_n_i  (sys_rst_n_o),
    .turbo_req_i  (turbo_req),
    .sd_ack_i     (sd_ack_i),
    .disk_motor_i (disk_motor_i),
    .disk_act_i   (disk_act_i),
    .bus_slot_i   (bus_slot_i),
    .dl_active_i  (dl_active_i),
    .turbo_o      (turbo_o),
    .led_user_o   (led_user_o)
  );

endmodule

`default_nettype wire

/* mac_pkg.sv */
// ====================
// shared widths, image map and register offsets for the housekeeping glue
// memory addresses count 16-bit words, download addresses count bytes
// ====================
`default_nettype none

package mac_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [24:0] dl_addr_t;
  typedef logic [24:0] mem_addr_t;
  typedef logic [7:0]  img_index_t;
  // latched code is 1 for 512KB, 2 for 1MB, 3 for 4MB
  typedef logic [1:0]  ram_size_t;
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_PENDING,
    LD_ARMED,
    LD_WRITING
  } ld_state_t;

  // download image selectors
  localparam img_index_t IMG_ROM        = 8'd0;
  localparam img_index_t IMG_FLOPPY_INT = 8'd1;
  localparam img_index_t IMG_FLOPPY_EXT = 8'd2;

  // ==================
  // image regions, above the region bit of the word space
  // ==================
  localparam mem_addr_t ROM_BASE        = 25'h1000000;
  localparam mem_addr_t FLOPPY_INT_BASE = 25'h1080000;
  localparam mem_addr_t FLOPPY_EXT_BASE = 25'h1100000;

  // final word address of an 800K and a 400K floppy image
  localparam mem_addr_t FLOPPY_DS_WORDS = 25'd409600;
  localparam mem_addr_t FLOPPY_SS_WORDS = 25'd204800;

  localparam apb_addr_t REG_CTRL   = 4'h0;
  localparam apb_addr_t REG_STATUS = 4'h4;

  // control register fields
  localparam int CTRL_TURBO    = 0;
  localparam int CTRL_SOFT_RST = 1;
  localparam int CTRL_WIDE     = 2;
  localparam int CTRL_MEM_LSB  = 4;

endpackage

`default_nettype wire

/* reset_seq.sv */
// ====================
// release latency depends on RESET_BITS and the cen rate
// a memory-size change only takes effect at the next reset
// ====================
`timescale 1ns/1ps
`default_nettype none

module reset_seq #(
  parameter int RESET_BITS = 16
) (
  input  logic               clk_sys,
  input  logic               RESET,
  input  logic               pll_locked_i,
  input  logic               soft_reset_i,
  input  logic               button_reset_i,
  input  logic               cen_i,
  input  mac_pkg::ram_size_t mem_size_i,
  output logic               sys_rst_n_o,
  output mac_pkg::ram_size_t ram_size_o
);
  import mac_pkg::*;

  logic [4:0]            sync_q;
  logic                  hold_rst;
  logic [RESET_BITS-1:0] cnt_q;

  // async assert, release through five flops
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[3:0], 1'b0};
    end
  end

  // any source keeps the machine in reset
  assign hold_rst = sync_q[4] | ~pll_locked_i | soft_reset_i | button_reset_i;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      cnt_q       <= '1;
      sys_rst_n_o <= 1'b0;
      ram_size_o  <= ram_size_t'(2'd1);
    end else if (hold_rst) begin
      cnt_q       <= '1;
      sys_rst_n_o <= 1'b0;
    end else if (cnt_q != '0) begin
      if (cen_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // field 0/1/2 maps to code 1/2/3
      ram_size_o <= ram_size_t'(mem_size_i + 2'd1);
    end else begin
      sys_rst_n_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
mac_pkg.sv
clk_enables.sv
reset_seq.sv
apb_cfg_regs.sv
image_loader.sv
drive_monitor.sv
mac_glue_top.sv
tb_mac_glue.sv

/* tb_mac_glue.sv */
// ====================
// drives the glue top through strobes, APB, reset, download and turbo
// bus slot runs a fixed 4-high 4-low pattern from its own counter
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_mac_glue;
  import mac_pkg::*;

  localparam int MAX_CYCLES = 4000;
  localparam int ROWS       = 6;

  logic       clk_sys = 1'b0;
  logic       RESET;
  logic       pll_locked_i;
  logic       button_reset_i;
  logic       psel_i;
  logic       penable_i;
  logic       pwrite_i;
  apb_addr_t  paddr_i;
  apb_data_t  pwdata_i;
  apb_data_t  prdata_o;
  logic       pready_o;
  logic       pslverr_o;
  logic       dl_active_i;
  img_index_t dl_index_i;
  logic       dl_wr_i;
  dl_addr_t   dl_addr_i;
  byte_t      dl_data_i;
  logic       dl_wait_o;
  logic       bus_slot_i;
  mem_addr_t  mem_addr_o;
  word_t      mem_din_o;
  logic       mem_we_o;
  logic [1:0] disk_eject_i;
  logic [1:0] disk_motor_i;
  logic [1:0] disk_act_i;
  logic       sd_ack_i;
  logic       cep_o;
  logic       ce_pixel_o;
  logic       sys_rst_n_o;
  ram_size_t  ram_size_o;
  logic [7:0] video_arx_o;
  logic [7:0] video_ary_o;
  logic       turbo_o;
  logic       led_user_o;

  int         err_count = 0;
  int         cycles = 0;
  logic [2:0] slot_cnt = 3'd0;

  // download table with one download per row
  img_index_t row_idx        [ROWS];
  dl_addr_t   row_addr       [ROWS];
  byte_t      row_even       [ROWS];
  byte_t      row_odd        [ROWS];
  mem_addr_t  row_exp_addr   [ROWS];
  word_t      row_exp_word   [ROWS];
  apb_data_t  row_exp_status [ROWS];

  mac_glue_top #(
    .RESET_BITS (4),
    .ACT_HOLD   (50),
    .TURBO_ACKS (3)
  ) dut0 (
    .clk_sys (clk_sys), .RESET (RESET),
    .pll_locked_i (pll_locked_i), .button_reset_i (button_reset_i),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
    .pready_o (pready_o), .pslverr_o (pslverr_o),
    .dl_active_i (dl_active_i), .dl_index_i (dl_index_i), .dl_wr_i (dl_wr_i),
    .dl_addr_i (dl_addr_i), .dl_data_i (dl_data_i), .dl_wait_o (dl_wait_o),
    .bus_slot_i (bus_slot_i), .mem_addr_o (mem_addr_o), .mem_din_o (mem_din_o),
    .mem_we_o (mem_we_o), .disk_eject_i (disk_eject_i),
    .disk_motor_i (disk_motor_i), .disk_act_i (disk_act_i), .sd_ack_i (sd_ack_i),
    .cep_o (cep_o), .ce_pixel_o (ce_pixel_o), .sys_rst_n_o (sys_rst_n_o),
    .ram_size_o (ram_size_o), .video_arx_o (video_arx_o),
    .video_ary_o (video_ary_o), .turbo_o (turbo_o), .led_user_o (led_user_o)
  );

  always #50 clk_sys = ~clk_sys;

  // loader slot runs 4 cycles high then 4 low
  always @(posedge clk_sys) begin
    slot_cnt   <= slot_cnt + 3'd1;
    bus_slot_i <= ~slot_cnt[2];
  end

  always @(posedge clk_sys) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ====================
  // compare tasks
  // ====================
  task automatic word_cmp(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic addr_cmp(input string name, input mem_addr_t got, input mem_addr_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic data_cmp(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic size_cmp(input string name, input ram_size_t got, input ram_size_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic ratio_cmp(input string name, input logic [7:0] got,
                           input logic [7:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic bit_cmp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic report(input string msg);
    $display("%0t %s", $time, msg);
    err_count++;
  endtask

  // ====================
  // APB transfers with setup then access phase
  // ====================
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge clk_sys);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_sys);
    penable_i <= 1'b1;
    @(negedge clk_sys);
    bit_cmp("pready_o", pready_o, 1'b1);
    @(posedge clk_sys);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(posedge clk_sys);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_sys);
    penable_i <= 1'b1;
    @(negedge clk_sys);
    bit_cmp("pready_o", pready_o, 1'b1);
    data = prdata_o;
    err  = pslverr_o;
    @(posedge clk_sys);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic wait_rst_release(input int limit);
    int n;
    n = 0;
    @(negedge clk_sys);
    while (!sys_rst_n_o && n < limit) begin
      @(negedge clk_sys);
      n++;
    end
    if (!sys_rst_n_o) begin
      report($sformatf("sys_rst_n_o did not rise within %0d cycles", limit));
    end
  endtask

  task automatic load_table();
    row_idx[0]  = IMG_ROM;
    row_addr[0] = 25'd0;
    row_idx[1]  = IMG_ROM;
    row_addr[1] = 25'd2;
    row_idx[2]  = IMG_FLOPPY_INT;
    row_addr[2] = 25'h100;
    row_idx[3]  = IMG_FLOPPY_EXT;
    row_addr[3] = 25'h2000;
    row_idx[4]  = IMG_FLOPPY_INT;
    row_addr[4] = 25'd819200;
    row_idx[5]  = IMG_FLOPPY_EXT;
    row_addr[5] = 25'd409600;
    // word address is the region base plus the byte address over two
    row_exp_addr[0] = 25'h1000000;
    row_exp_addr[1] = 25'h1000001;
    row_exp_addr[2] = 25'h1080080;
    row_exp_addr[3] = 25'h1101000;
    row_exp_addr[4] = 25'h10e4000;
    row_exp_addr[5] = 25'h1132000;
    // odd-sized floppies clear their drive
    // 800K sets ins and ds while 400K sets ins only
    row_exp_status[0] = 32'h0;
    row_exp_status[1] = 32'h0;
    row_exp_status[2] = 32'h0;
    row_exp_status[3] = 32'h0;
    row_exp_status[4] = 32'h3;
    row_exp_status[5] = 32'h7;
    for (int r = 0; r < ROWS; r++) begin
      row_even[r]     = byte_t'($urandom);
      row_odd[r]      = byte_t'($urandom);
      row_exp_word[r] = {row_even[r], row_odd[r]};
    end
  endtask

  // one pair download followed by the paced write and the drive flags
  task automatic run_row(input int r);
    int        waited;
    int        we_seen;
    apb_data_t rdata;
    logic      err;
    @(posedge clk_sys);
    dl_active_i <= 1'b1;
    dl_index_i  <= row_idx[r];
    @(posedge clk_sys);
    dl_wr_i   <= 1'b1;
    dl_addr_i <= row_addr[r];
    dl_data_i <= row_even[r];
    @(posedge clk_sys);
    dl_addr_i <= row_addr[r] | 25'd1;
    dl_data_i <= row_odd[r];
    @(posedge clk_sys);
    dl_wr_i <= 1'b0;
    @(negedge clk_sys);
    bit_cmp("dl_wait_o", dl_wait_o, 1'b1);
    waited  = 0;
    we_seen = 0;
    while (dl_wait_o && waited < 40) begin
      bit_cmp("led_user_o", led_user_o, 1'b1);
      if (mem_we_o) begin
        we_seen++;
        bit_cmp("bus_slot_i at mem_we_o", bus_slot_i, 1'b1);
        addr_cmp("mem_addr_o", mem_addr_o, row_exp_addr[r]);
        word_cmp("mem_din_o", mem_din_o, row_exp_word[r]);
      end
      @(negedge clk_sys);
      waited++;
    end
    if (dl_wait_o) begin
      report($sformatf("dl_wait_o stuck high on row %0d", r));
    end
    // the write covers one whole slot of 4 cycles
    if (we_seen != 4) begin
      report($sformatf("row %0d wrote for %0d cycles instead of one whole slot",
                       r, we_seen));
    end
    bit_cmp("mem_we_o", mem_we_o, 1'b0);
    @(posedge clk_sys);
    dl_active_i <= 1'b0;
    repeat (2) @(posedge clk_sys);
    apb_read(REG_STATUS, rdata, err);
    data_cmp("status", rdata, row_exp_status[r]);
    bit_cmp("pslverr_o", err, 1'b0);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    int          c0;
    int          n;
    apb_data_t   rdata;
    logic        err;
    RESET          = 1'b1;
    pll_locked_i   = 1'b1;
    button_reset_i = 1'b0;
    psel_i         = 1'b0;
    penable_i      = 1'b0;
    pwrite_i       = 1'b0;
    paddr_i        = '0;
    pwdata_i       = '0;
    dl_active_i    = 1'b0;
    dl_index_i     = '0;
    dl_wr_i        = 1'b0;
    dl_addr_i      = '0;
    dl_data_i      = '0;
    bus_slot_i     = 1'b0;
    disk_eject_i   = '0;
    disk_motor_i   = '0;
    disk_act_i     = '0;
    sd_ack_i       = 1'b0;
    void'($urandom(32'h23a3));
    load_table();

    repeat (8) @(posedge clk_sys);
    RESET <= 1'b0;
    wait_rst_release(300);
    size_cmp("ram_size_o", ram_size_o, 2'd1);

    // cep every 8 cycles with the late phase 4 after it and pixel every 4
    c0 = -1;
    for (int i = 0; i < 64; i++) begin
      @(negedge clk_sys);
      if (c0 < 0 && cep_o) begin
        c0 = i;
      end
      if (c0 >= 0) begin
        bit_cmp("cep_o", cep_o, ((i - c0) % 8) == 0);
        bit_cmp("cen", dut0.cen, ((i - c0) % 8) == 4);
        bit_cmp("ce_pixel_o", ce_pixel_o, ((i - c0) % 4) == 0);
      end else if (i == 7) begin
        report("cep_o did not pulse in the first 8 cycles");
      end
    end

    // APB control readback and aspect outputs
    apb_write(REG_CTRL, 32'h24);
    apb_read(REG_CTRL, rdata, err);
    data_cmp("prdata_o", rdata, 32'h24);
    bit_cmp("pslverr_o", err, 1'b0);
    ratio_cmp("video_arx_o", video_arx_o, 8'd16);
    ratio_cmp("video_ary_o", video_ary_o, 8'd9);
    apb_write(REG_CTRL, 32'h20);
    @(negedge clk_sys);
    ratio_cmp("video_arx_o", video_arx_o, 8'd4);
    ratio_cmp("video_ary_o", video_ary_o, 8'd3);
    apb_read(4'h8, rdata, err);
    bit_cmp("pslverr_o", err, 1'b1);

    // memory field 2 under soft reset gives code 3 on release
    apb_write(REG_CTRL, 32'h22);
    repeat (3) @(negedge clk_sys);
    bit_cmp("sys_rst_n_o", sys_rst_n_o, 1'b0);
    apb_write(REG_CTRL, 32'h20);
    wait_rst_release(200);
    size_cmp("ram_size_o", ram_size_o, 2'd3);

    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end

    // eject of the internal drive
    @(posedge clk_sys);
    disk_eject_i <= 2'b01;
    @(posedge clk_sys);
    disk_eject_i <= 2'b00;
    apb_read(REG_STATUS, rdata, err);
    data_cmp("status", rdata, 32'h4);

    // turbo held off until the third ack falls
    apb_write(REG_CTRL, 32'h21);
    repeat (10) begin
      @(negedge clk_sys);
      bit_cmp("turbo_o", turbo_o, 1'b0);
    end
    for (int k = 0; k < 3; k++) begin
      @(posedge clk_sys);
      sd_ack_i <= 1'b1;
      @(posedge clk_sys);
      @(posedge clk_sys);
      sd_ack_i <= 1'b0;
      if (k < 2) begin
        repeat (10) begin
          @(negedge clk_sys);
          bit_cmp("turbo_o", turbo_o, 1'b0);
        end
      end
    end
    n = 0;
    @(negedge clk_sys);
    while (!turbo_o && n < 20) begin
      @(negedge clk_sys);
      n++;
    end
    if (!turbo_o) begin
      report("turbo_o not set within 20 cycles of the third ack");
    end
    apb_read(REG_STATUS, rdata, err);
    data_cmp("status", rdata, 32'h14);

    $display("run complete after %0d cycles, %0d errors", cycles, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
